/* common/pd_cfg.svh */
`ifndef PD_CFG_SVH
`define PD_CFG_SVH

// Fetch packet geometry.
`define PD_HALVES 8

// Instruction slots handed to decode per cycle.
`define PD_SLOTS 4

// Packets held between fetch and the aligner.
`define PD_QDEPTH 4

// Global branch history length.
`define PD_HIST 8

`endif

/* common/pdPkg.sv */
`include "pd_cfg.svh"

package pdPkg;

    typedef logic [2:0]          halfIdx_t;
    typedef logic [27:0]         fetchAddr_t;
    typedef logic [30:0]         instrAddr_t;
    typedef logic [4:0]          fetchId_t;
    typedef logic [`PD_HIST-1:0] bHist_t;

    typedef enum logic [1:0] {
        FAULT_NONE   = 2'd0,
        FAULT_PAGE   = 2'd1,
        FAULT_ACCESS = 2'd2
    } fetchFault_t;

    typedef enum logic [1:0] {
        CLS_OTHER  = 2'd0,
        CLS_BRANCH = 2'd1,
        CLS_JAL    = 2'd2,
        CLS_JALR   = 2'd3
    } instrClass_t;

    // One fetch packet as delivered by the fetch unit.
    typedef struct packed {
        fetchAddr_t                   addr;
        fetchId_t                     fetchId;
        fetchFault_t                  fault;
        halfIdx_t                     firstValid;
        halfIdx_t                     lastValid;
        halfIdx_t                     predPos;
        logic                         predTaken;
        instrAddr_t                   predTarget;
        bHist_t                       history;
        logic [`PD_HALVES-1:0][15:0]  halves;
    } fetchPkt_t;

    // One instruction cut out of the halfword stream.
    typedef struct packed {
        logic        valid;
        instrAddr_t  addr;
        logic [31:0] instr;
        fetchId_t    fetchId;
        fetchFault_t fault;
        logic        predTaken;
        logic        predInvalid;
        instrAddr_t  predTarget;
        bHist_t      history;
    } alignedInstr_t;

    typedef struct packed {
        alignedInstr_t ins;
        logic          compressed;
        instrClass_t   cls;
    } pdSlot_t;

endpackage

/* predecode/fetchQueue.sv */
`timescale 1ns/1ns
`include "pd_cfg.svh"

module fetchQueue (
    input  logic             clk,
    input  logic             rst,
    input  logic             mispred,
    input  logic             push,
    input  pdPkg::fetchPkt_t pushPkt,
    input  logic [1:0]       popCount,
    output pdPkg::fetchPkt_t head,
    output pdPkg::fetchPkt_t next,
    output logic             headValid,
    output logic             nextValid,
    output logic             full
);
    import pdPkg::*;

    localparam int PtrW = $clog2(`PD_QDEPTH);
    localparam int CntW = PtrW + 1;

    fetchPkt_t mem [`PD_QDEPTH];

    logic [PtrW-1:0] rdPtr;
    logic [PtrW-1:0] wrPtr;
    logic [CntW-1:0] freeCnt;
    logic [CntW-1:0] freeNext;
    logic            doPush;

    // A flush wins over a push in the same cycle.
    assign doPush = push && !mispred;

    assign freeNext = freeCnt + CntW'(popCount) - CntW'(doPush);

    // ------------------------------------------------------------------------
    // Read side
    // ------------------------------------------------------------------------

    // The aligner sees the two oldest packets at once so that a 32-bit
    // instruction can be joined across a packet boundary.
    assign head = mem[rdPtr];
    assign next = mem[rdPtr + PtrW'(1)];

    assign headValid = freeCnt != CntW'(`PD_QDEPTH);
    assign nextValid = freeCnt < CntW'(`PD_QDEPTH - 1);

    // ------------------------------------------------------------------------
    // Storage and pointers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushPkt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            rdPtr   <= '0;
            wrPtr   <= '0;
            freeCnt <= CntW'(`PD_QDEPTH);
            full    <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + PtrW'(1);
            end
            rdPtr   <= rdPtr + PtrW'(popCount);
            freeCnt <= freeNext;

            // Fetch only sees full a cycle late, so one entry is kept spare
            // for the packet that may already be on its way.
            full <= freeNext <= CntW'(1);
        end
    end

endmodule

/* predecode/instrAligner.sv */
`timescale 1ns/1ns
`include "pd_cfg.svh"

module instrAligner (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mispred,
    input  logic                  outEn,
    input  pdPkg::fetchPkt_t      head,
    input  pdPkg::fetchPkt_t      next,
    input  logic                  headValid,
    input  logic                  nextValid,
    output logic [1:0]            popCount,
    output pdPkg::alignedInstr_t  aligned [`PD_SLOTS]
);
    import pdPkg::*;

    // Start index inside the head packet. When fresh is set the head has not
    // been touched yet and the walk begins at its firstValid instead.
    halfIdx_t startIdx;
    logic     fresh;
    halfIdx_t advance;

    // ------------------------------------------------------------------------
    // Halfword walk
    // ------------------------------------------------------------------------

    always_comb begin : walk
        fetchPkt_t  cur;
        fetchPkt_t  lastPkt;
        logic [1:0] sel;
        halfIdx_t   idx;
        halfIdx_t   lastIdx;
        logic       lastInNext;
        logic [15:0] lo;
        logic [15:0] hi;
        logic       avail;
        logic       stalled;
        logic       faulted;
        logic       predHere;
        logic       wide;
        logic       predInv;

        sel     = 2'd0;
        idx     = fresh ? head.firstValid : startIdx;
        stalled = !outEn;

        for (int i = 0; i < `PD_SLOTS; i++) begin
            aligned[i] = '0;

            // sel counts packets already finished this cycle: 0 is the head,
            // 1 is the next packet, 2 means both are used up.
            cur   = (sel == 2'd0) ? head : next;
            avail = (sel == 2'd0) ? headValid : ((sel == 2'd1) && nextValid);

            lo       = cur.halves[idx];
            faulted  = cur.fault != FAULT_NONE;
            predHere = cur.predTaken && (cur.predPos == idx);
            wide     = (lo[1:0] == 2'b11) && !faulted;

            // Fetch marks a taken branch on the last halfword of an
            // instruction. A mark on the first half of a 32-bit one is bogus.
            predInv = wide && predHere;

            hi         = '0;
            lastPkt    = cur;
            lastIdx    = idx;
            lastInNext = 1'b0;

            if (wide && !predInv) begin
                if (idx != cur.lastValid) begin
                    hi      = cur.halves[idx + 3'd1];
                    lastIdx = idx + 3'd1;
                end else begin
                    hi         = next.halves[next.firstValid];
                    lastPkt    = next;
                    lastIdx    = next.firstValid;
                    lastInNext = 1'b1;
                    // The upper half is not here yet, so this slot waits.
                    if (sel != 2'd0 || !nextValid) begin
                        avail = 1'b0;
                    end
                end
            end

            if (stalled || !avail) begin
                stalled = 1'b1;
            end else begin
                aligned[i].valid       = 1'b1;
                aligned[i].addr        = {cur.addr, idx};
                aligned[i].instr       = {hi, lo};
                aligned[i].fetchId     = cur.fetchId;
                aligned[i].fault       = cur.fault;
                aligned[i].predTaken   = lastPkt.predTaken && (lastPkt.predPos == lastIdx);
                aligned[i].predInvalid = predInv;
                aligned[i].predTarget  = cur.predTarget;

                // Anything behind the predicted position saw a not-taken branch.
                if (idx > cur.predPos) begin
                    aligned[i].history = {cur.history[`PD_HIST-2:0], 1'b0};
                end else begin
                    aligned[i].history = cur.history;
                end

                if (lastIdx == lastPkt.lastValid) begin
                    sel = sel + 2'd1 + {1'b0, lastInNext};
                    idx = next.firstValid;
                end else begin
                    sel = sel + {1'b0, lastInNext};
                    idx = lastIdx + 3'd1;
                end
            end
        end

        popCount = sel;
        advance  = idx;
    end

    // ------------------------------------------------------------------------
    // Start index
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst || mispred) begin
            startIdx <= '0;
            fresh    <= 1'b1;
        end else if (outEn) begin
            if (popCount == 2'd0) begin
                if (headValid) begin
                    startIdx <= advance;
                    fresh    <= 1'b0;
                end
            end else if (popCount == 2'd1 && nextValid) begin
                // The old next packet becomes head and the walk already
                // knows where it stopped inside it.
                startIdx <= advance;
                fresh    <= 1'b0;
            end else begin
                fresh <= 1'b1;
            end
        end
    end

endmodule

/* design/instrClassify.sv */
`timescale 1ns/1ns
`include "pd_cfg.svh"

module instrClassify (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 mispred,
    input  pdPkg::alignedInstr_t aligned [`PD_SLOTS],
    output pdPkg::pdSlot_t       slots [`PD_SLOTS]
);
    import pdPkg::*;

    function automatic instrClass_t classOf(input logic [31:0] instr);
        instrClass_t cls;

        cls = CLS_OTHER;
        if (instr[1:0] == 2'b11) begin
            case (instr[6:0])
                7'b1100011: cls = CLS_BRANCH;
                7'b1101111: cls = CLS_JAL;
                7'b1100111: cls = CLS_JALR;
                default:    cls = CLS_OTHER;
            endcase
        end else if (instr[1:0] == 2'b01) begin
            // Quadrant 1 holds c.jal, c.j, c.beqz and c.bnez.
            case (instr[15:13])
                3'b001, 3'b101: cls = CLS_JAL;
                3'b110, 3'b111: cls = CLS_BRANCH;
                default:        cls = CLS_OTHER;
            endcase
        end else if (instr[1:0] == 2'b10 && instr[15:13] == 3'b100 &&
                     instr[11:7] != 5'd0 && instr[6:2] == 5'd0) begin
            // c.jr and c.jalr. A zero rs1 would be c.ebreak or reserved.
            cls = CLS_JALR;
        end
        return cls;
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < `PD_SLOTS; i++) begin
            slots[i].ins        <= aligned[i];
            slots[i].compressed <= aligned[i].instr[1:0] != 2'b11;
            slots[i].cls        <= classOf(aligned[i].instr);
            if (rst || mispred) begin
                slots[i].ins.valid <= 1'b0;
            end
        end
    end

endmodule

/* design/pdTop.sv */
`timescale 1ns/1ns
`include "pd_cfg.svh"

module pdTop (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetchValid,
    input  pdPkg::fetchPkt_t fetchPkt,
    input  logic             mispred,
    input  logic             outEn,
    output logic             full,
    output pdPkg::pdSlot_t   slots [`PD_SLOTS]
);
    import pdPkg::*;

    fetchPkt_t     head;
    fetchPkt_t     next;
    logic          headValid;
    logic          nextValid;
    logic [1:0]    popCount;
    alignedInstr_t aligned [`PD_SLOTS];

    // ------------------------------------------------------------------------
    // Packet queue
    // ------------------------------------------------------------------------

    fetchQueue queue_i (
        .clk       (clk),
        .rst       (rst),
        .mispred   (mispred),
        .push      (fetchValid),
        .pushPkt   (fetchPkt),
        .popCount  (popCount),
        .head      (head),
        .next      (next),
        .headValid (headValid),
        .nextValid (nextValid),
        .full      (full)
    );

    // ------------------------------------------------------------------------
    // Aligner and output stage
    // ------------------------------------------------------------------------

    instrAligner aligner_i (
        .clk       (clk),
        .rst       (rst),
        .mispred   (mispred),
        .outEn     (outEn),
        .head      (head),
        .next      (next),
        .headValid (headValid),
        .nextValid (nextValid),
        .popCount  (popCount),
        .aligned   (aligned)
    );

    instrClassify classify_i (
        .clk     (clk),
        .rst     (rst),
        .mispred (mispred),
        .aligned (aligned),
        .slots   (slots)
    );

endmodule

/* test/pdModel.svh */
`ifndef PD_MODEL_SVH
`define PD_MODEL_SVH

// Expected slots in program order, plus the lower half of a 32-bit
// instruction that still waits for the following packet.
pdSlot_t   expQ[$];
logic      carryOn;
fetchPkt_t carryPkt;
int        carryIdx;

function automatic instrClass_t expectedClass(input logic [31:0] instr);
    logic [2:0] f3;

    f3 = instr[15:13];
    if (instr[1:0] == 2'b11) begin
        if (instr[6:0] == 7'b1100011) return CLS_BRANCH;
        if (instr[6:0] == 7'b1101111) return CLS_JAL;
        if (instr[6:0] == 7'b1100111) return CLS_JALR;
        return CLS_OTHER;
    end
    // c.jal and c.j, then c.beqz and c.bnez.
    if (instr[1:0] == 2'b01 && (f3 == 3'b001 || f3 == 3'b101)) return CLS_JAL;
    if (instr[1:0] == 2'b01 && f3[2:1] == 2'b11) return CLS_BRANCH;
    // c.jr and c.jalr need a nonzero rs1 and a zero rs2.
    if (instr[1:0] == 2'b10 && f3 == 3'b100 && instr[11:7] != 5'd0 && instr[6:2] == 5'd0) begin
        return CLS_JALR;
    end
    return CLS_OTHER;
endfunction

function automatic pdSlot_t makeSlot(input fetchPkt_t p, input int idx, input logic [15:0] hi,
                                     input logic taken, input logic predInv);
    pdSlot_t s;

    s                   = '0;
    s.ins.valid         = 1'b1;
    s.ins.addr          = {p.addr, 3'(idx)};
    s.ins.instr         = {hi, p.halves[idx]};
    s.ins.fetchId       = p.fetchId;
    s.ins.fault         = p.fault;
    s.ins.predTaken     = taken;
    s.ins.predInvalid   = predInv;
    s.ins.predTarget    = p.predTarget;
    s.ins.history       = p.history;
    if (idx > int'(p.predPos)) begin
        s.ins.history = {p.history[`PD_HIST-2:0], 1'b0};
    end
    s.compressed        = s.ins.instr[1:0] != 2'b11;
    s.cls               = expectedClass(s.ins.instr);
    return s;
endfunction

task automatic modelPush(input fetchPkt_t p);
    int   idx;
    logic wide;
    logic hit;

    idx = int'(p.firstValid);
    if (carryOn) begin
        expQ.push_back(makeSlot(carryPkt, carryIdx, p.halves[idx],
                                p.predTaken && int'(p.predPos) == idx, 1'b0));
        carryOn = 1'b0;
        idx++;
    end
    while (idx <= int'(p.lastValid)) begin
        hit  = p.predTaken && int'(p.predPos) == idx;
        wide = p.halves[idx][1:0] == 2'b11 && p.fault == FAULT_NONE;
        if (wide && hit) begin
            expQ.push_back(makeSlot(p, idx, 16'h0, 1'b1, 1'b1));
            idx++;
        end else if (wide && idx == int'(p.lastValid)) begin
            carryOn  = 1'b1;
            carryPkt = p;
            carryIdx = idx;
            idx++;
        end else if (wide) begin
            expQ.push_back(makeSlot(p, idx, p.halves[idx + 1],
                                    p.predTaken && int'(p.predPos) == idx + 1, 1'b0));
            idx += 2;
        end else begin
            expQ.push_back(makeSlot(p, idx, 16'h0, hit, 1'b0));
            idx++;
        end
    end
endtask

`endif

/* test/pdTb.sv */
`timescale 1ns/1ns
`include "pd_cfg.svh"

module pdTb;
    import pdPkg::*;

    logic      clk = 1'b0;
    logic      rst;
    logic      fetchValid;
    fetchPkt_t fetchPkt;
    logic      mispred;
    logic      outEn;
    logic      full;
    pdSlot_t   slots [`PD_SLOTS];

    fetchAddr_t nextAddr;
    fetchId_t   nextId;
    string      testName;
    logic       prevOutEn;
    logic       prevFlush;

    `include "pdModel.svh"

    pdTop dut_i (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchPkt   (fetchPkt),
        .mispred    (mispred),
        .outEn      (outEn),
        .full       (full),
        .slots      (slots)
    );

    always #4 clk = ~clk;

    task automatic stopRun(input string why);
        $display("%s: %s", testName, why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic reportMismatch(input pdSlot_t exp, input pdSlot_t act);
        $display("ERR %s: expected %h actual %h", testName, exp, act);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------------------

    always @(negedge clk) begin : scoreboard
        pdSlot_t exp;
        if (!rst) begin
            for (int i = 0; i < `PD_SLOTS; i++) begin
                if (slots[i].ins.valid) begin
                    assert (prevOutEn && !prevFlush)
                        else stopRun("slot valid while decode was disabled or after a flush");
                    assert (expQ.size() > 0)
                        else stopRun("DUT produced an instruction the model did not expect");
                    exp = expQ.pop_front();
                    assert (slots[i] === exp) else reportMismatch(exp, slots[i]);
                end
            end
            if (prevFlush) begin
                assert (full == 1'b0) else stopRun("full still high after a flush");
            end
        end
        prevOutEn = outEn;
        prevFlush = mispred;
        if (mispred) begin
            expQ.delete();
            carryOn = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    task automatic idleCycle();
        @(posedge clk);
        #1;
    endtask

    function automatic fetchPkt_t randomPacket(input bit lastOne, input bit allowFault,
                                               input int predOdds);
        fetchPkt_t   p;
        int          fv;
        logic [15:0] h;

        p          = '0;
        p.addr     = nextAddr;
        p.fetchId  = nextId;
        nextAddr   = nextAddr + 28'd1;
        nextId     = nextId + 5'd1;
        fv         = int'($urandom % 8);
        p.firstValid = 3'(fv);
        p.lastValid  = 3'(fv + int'($urandom % (8 - fv)));
        p.predPos    = 3'($urandom % 8);
        p.predTaken  = ($urandom % predOdds) == 0;
        p.predTarget = 31'($urandom);
        p.history    = `PD_HIST'($urandom);
        if (allowFault && ($urandom % 6) == 0) begin
            p.fault = ($urandom % 2) ? FAULT_PAGE : FAULT_ACCESS;
        end
        for (int i = 0; i < `PD_HALVES; i++) begin
            h = 16'($urandom);
            if ($urandom % 2 == 0) begin
                h[1:0] = 2'b11;
                case ($urandom % 8)
                    0: h[6:0] = 7'b1100011;
                    1: h[6:0] = 7'b1101111;
                    2: h[6:0] = 7'b1100111;
                    default: h[6:0] = h[6:0];
                endcase
            end else begin
                h[1:0] = 2'($urandom % 3);
            end
            // The closing packet of a burst holds only 16-bit parcels.
            if (lastOne) begin
                h[1:0] = 2'b00;
            end
            p.halves[i] = h;
        end
        return p;
    endfunction

    task automatic pushPacket(input fetchPkt_t p);
        for (int t = 0; t < 100 && full; t++) begin
            idleCycle();
        end
        if (full) begin
            stopRun("full never dropped, fetch could not push");
        end
        fetchValid = 1'b1;
        fetchPkt   = p;
        modelPush(p);
        idleCycle();
        fetchValid = 1'b0;
    endtask

    task automatic drainStream();
        for (int t = 0; t < 300 && expQ.size() != 0; t++) begin
            idleCycle();
        end
        if (expQ.size() != 0) begin
            stopRun("timed out waiting for the expected instructions");
        end
        repeat (4) idleCycle();
    endtask

    task automatic checkIdleOutputs();
        for (int i = 0; i < `PD_SLOTS; i++) begin
            assert (slots[i].ins.valid == 1'b0) else stopRun("slot valid when it should be idle");
        end
        assert (full == 1'b0) else stopRun("full high when the queue should be empty");
    endtask

    initial begin
        fetchPkt_t p;

        void'($urandom(75943));
        rst        = 1'b1;
        fetchValid = 1'b0;
        fetchPkt   = '0;
        mispred    = 1'b0;
        outEn      = 1'b1;
        nextAddr   = 28'h0100;
        nextId     = '0;
        carryOn    = 1'b0;
        testName   = "reset";
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) idleCycle();
        checkIdleOutputs();

        testName = "stream";
        outEn = 1'b1;
        repeat (30) pushPacket(randomPacket(0, 0, 8));
        pushPacket(randomPacket(1, 0, 8));
        drainStream();

        // A lone 32-bit parcel at the end of a packet, joined with the next.
        testName = "span";
        p = randomPacket(1, 0, 8);
        p.predTaken = 1'b0;
        p.lastValid = 3'd7;
        p.halves[7][1:0] = 2'b11;
        pushPacket(p);
        p = randomPacket(1, 0, 8);
        p.predTaken = 1'b0;
        pushPacket(p);
        drainStream();

        testName = "backpressure";
        outEn = 1'b0;
        for (int n = 0; n < 8 && !full; n++) begin
            pushPacket(randomPacket(0, 0, 8));
        end
        assert (full) else stopRun("full did not rise with decode stalled");
        repeat (5) idleCycle();
        outEn = 1'b1;
        repeat (4) pushPacket(randomPacket(0, 0, 8));
        pushPacket(randomPacket(1, 0, 8));
        drainStream();

        testName = "predfault";
        repeat (40) pushPacket(randomPacket(0, 1, 2));
        pushPacket(randomPacket(1, 1, 2));
        drainStream();

        testName = "flush";
        outEn = 1'b0;
        repeat (3) pushPacket(randomPacket(0, 0, 4));
        outEn   = 1'b1;
        mispred = 1'b1;
        idleCycle();
        mispred = 1'b0;
        checkIdleOutputs();
        repeat (10) pushPacket(randomPacket(0, 1, 4));
        pushPacket(randomPacket(1, 0, 4));
        drainStream();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+common
+incdir+test
common/pdPkg.sv
predecode/fetchQueue.sv
predecode/instrAligner.sv
design/instrClassify.sv
design/pdTop.sv
test/pdTb.sv

/* run.sh */
#!/bin/sh
# Build and run the predecode testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pdTb -f all.f -o simv \
    > build.log 2>&1 || { cat build.log; echo "TEST FAIL" > sim.log; }
[ -f sim.log ] || ./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0
